// File: project.f
+incdir+rtl
rtl/ks_word_pkg.sv
rtl/ks_prefix_pkg.sv
rtl/ks_pg_stage.sv
rtl/ks_prefix_level.sv
rtl/ks_sum_stage.sv
rtl/ks_adder.sv
test/tb_ks_adder.sv

// File: rtl/ks_adder.sv
`include "ks_cfg.svh"

module ks_adder
	import ks_word_pkg::*;
	import ks_prefix_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	input  logic  in_valid,
	output logic  in_ready,
	input  word_t a,
	input  word_t b,
	input  logic  cin,

	output logic  out_valid,
	input  logic  out_ready,
	output word_t sum,
	output logic  cout
);

	// Slot l feeds prefix level l, slot KS_LEVELS feeds the sum stage
	logic [`KS_LEVELS:0] lvl_valid;
	logic [`KS_LEVELS:0] lvl_ready;
	pg_vec_t             lvl_gen [`KS_LEVELS+1];
	pg_vec_t             lvl_prop [`KS_LEVELS+1];
	half_sum_t           lvl_half_sum [`KS_LEVELS+1];

	//////////////////////////////
	// Pre-processing
	//////////////////////////////

	ks_pg_stage u_pg_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (lvl_valid[0]),
		.out_ready (lvl_ready[0]),
		.gen       (lvl_gen[0]),
		.prop      (lvl_prop[0]),
		.half_sum  (lvl_half_sum[0])
	);

	//////////////////////////////
	// Prefix tree
	//////////////////////////////

	// Distance doubles every level
	for (genvar l = 0; l < `KS_LEVELS; l++) begin : g_level
		ks_prefix_level #(
			.DIST (1 << l)
		) u_prefix_level (
			.clk          (clk),
			.rst_n        (rst_n),
			.in_valid     (lvl_valid[l]),
			.in_ready     (lvl_ready[l]),
			.gen_in       (lvl_gen[l]),
			.prop_in      (lvl_prop[l]),
			.half_sum_in  (lvl_half_sum[l]),
			.out_valid    (lvl_valid[l+1]),
			.out_ready    (lvl_ready[l+1]),
			.gen_out      (lvl_gen[l+1]),
			.prop_out     (lvl_prop[l+1]),
			.half_sum_out (lvl_half_sum[l+1])
		);
	end

	//////////////////////////////
	// Sum
	//////////////////////////////

	// Last propagate vector has no consumer
	ks_sum_stage u_sum_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (lvl_valid[`KS_LEVELS]),
		.in_ready    (lvl_ready[`KS_LEVELS]),
		.gen_in      (lvl_gen[`KS_LEVELS]),
		.half_sum_in (lvl_half_sum[`KS_LEVELS]),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.sum         (sum),
		.cout        (cout)
	);

endmodule

// File: rtl/ks_cfg.svh
`ifndef KS_CFG_SVH
`define KS_CFG_SVH

//////////////////////////////
// Adder geometry
//////////////////////////////

// Operand width, must be a power of two
`define KS_WIDTH 32

// Prefix levels, log2 of the width
// Distances run 1, 2, 4 ... KS_WIDTH/2
`define KS_LEVELS 5

`endif

// File: rtl/ks_pg_stage.sv
module ks_pg_stage
	import ks_word_pkg::*;
	import ks_prefix_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	output logic      in_ready,
	input  word_t     a,
	input  word_t     b,
	input  logic      cin,

	output logic      out_valid,
	input  logic      out_ready,
	output pg_vec_t   gen,
	output pg_vec_t   prop,
	output half_sum_t half_sum
);

	pg_vec_t   gen_nxt;
	pg_vec_t   prop_nxt;
	half_sum_t half_sum_nxt;
	logic      load;

	//////////////////////////////
	// Bitwise generate/propagate
	//////////////////////////////

	// Carry-in sits at position zero as a pure generate
	assign gen_nxt      = {a & b, cin};
	assign prop_nxt     = {a | b, 1'b1};
	assign half_sum_nxt = a ^ b;

	//////////////////////////////
	// Pipeline register
	//////////////////////////////

	// Accept when empty or when the slot drains this cycle
	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			gen      <= gen_nxt;
			prop     <= prop_nxt;
			half_sum <= half_sum_nxt;
		end
	end

endmodule

// File: rtl/ks_prefix_level.sv
`include "ks_cfg.svh"

module ks_prefix_level
	import ks_prefix_pkg::*;
#(
	parameter int DIST = 1
) (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	output logic      in_ready,
	input  pg_vec_t   gen_in,
	input  pg_vec_t   prop_in,
	input  half_sum_t half_sum_in,

	output logic      out_valid,
	input  logic      out_ready,
	output pg_vec_t   gen_out,
	output pg_vec_t   prop_out,
	output half_sum_t half_sum_out
);

	pg_vec_t gen_nxt;
	pg_vec_t prop_nxt;
	logic    load;

	//////////////////////////////
	// Combining level
	//////////////////////////////

	// Each position i looks back to i - DIST
	for (genvar i = 0; i <= `KS_WIDTH; i++) begin : g_pos
		if (i < DIST) begin : g_pass
			// Already resolved down to carry-in
			assign gen_nxt[i]  = gen_in[i];
			assign prop_nxt[i] = prop_in[i];
		end else if (i < 2 * DIST) begin : g_grey
			// Span reaches position zero, only the carry matters now
			assign gen_nxt[i]  = gen_in[i] | (prop_in[i] & gen_in[i-DIST]);
			assign prop_nxt[i] = 1'b0;
		end else begin : g_black
			assign gen_nxt[i]  = gen_in[i] | (prop_in[i] & gen_in[i-DIST]);
			assign prop_nxt[i] = prop_in[i] & prop_in[i-DIST];
		end
	end

	//////////////////////////////
	// Pipeline register
	//////////////////////////////

	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Half-sum is not touched by the tree
	always_ff @(posedge clk) begin
		if (load) begin
			gen_out      <= gen_nxt;
			prop_out     <= prop_nxt;
			half_sum_out <= half_sum_in;
		end
	end

endmodule

// File: rtl/ks_prefix_pkg.sv
`include "ks_cfg.svh"

// Carry network types
package ks_prefix_pkg;

	// Index 0 is carry-in, index i+1 belongs to operand bit i
	// Used for both generate and propagate
	typedef logic [`KS_WIDTH:0] pg_vec_t;

	// Per-bit a ^ b, rides along with the prefix vectors
	typedef logic [`KS_WIDTH-1:0] half_sum_t;

endpackage

// File: rtl/ks_sum_stage.sv
`include "ks_cfg.svh"

module ks_sum_stage
	import ks_word_pkg::*;
	import ks_prefix_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	output logic      in_ready,
	input  pg_vec_t   gen_in,
	input  half_sum_t half_sum_in,

	output logic      out_valid,
	input  logic      out_ready,
	output word_t     sum,
	output logic      cout
);

	word_t sum_nxt;
	logic  cout_nxt;
	logic  msb_carry;
	logic  load;

	//////////////////////////////
	// Final XOR and carry-out
	//////////////////////////////

	// Group generate at index i is the carry into bit i
	assign sum_nxt   = half_sum_in ^ gen_in[`KS_WIDTH-1:0];
	assign msb_carry = gen_in[`KS_WIDTH-1];

	// Top span ends at bit 0 and misses cin,
	// so close it through the carry into the msb
	assign cout_nxt = gen_in[`KS_WIDTH] | (half_sum_in[`KS_WIDTH-1] & msb_carry);

	//////////////////////////////
	// Output register
	//////////////////////////////

	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			sum  <= sum_nxt;
			cout <= cout_nxt;
		end
	end

endmodule

// File: rtl/ks_word_pkg.sv
`include "ks_cfg.svh"

// Words seen at the adder boundary
package ks_word_pkg;

	// Operand a, operand b and the sum
	typedef logic [`KS_WIDTH-1:0] word_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f project.f --top-module tb_ks_adder \
	-o tb_ks_adder > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ks_adder > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

// File: test/tb_ks_adder.sv
`include "ks_cfg.svh"

module tb_ks_adder
	import ks_word_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ADDS        = 2000;
	localparam int TIMEOUT_CYCLES  = 3 * NUM_ADDS + 100;
	localparam int LATENCY         = `KS_LEVELS + 2;
	localparam int BURST_AT        = 1500;
	localparam int BURST_LEN       = 20;
	localparam int CORNER_RIPPLE   = 100;
	localparam int CORNER_ONES     = 200;
	localparam int CORNER_ONES_CIN = 300;
	localparam int CORNER_ZERO     = 400;

	// Carry-out on top of the sum
	typedef logic [`KS_WIDTH:0] wide_t;

	logic  clk = 1'b0;
	logic  rst_n;
	logic  in_valid;
	logic  in_ready;
	word_t a;
	word_t b;
	logic  cin;
	logic  out_valid;
	logic  out_ready;
	word_t sum;
	logic  cout;

	// Driver state
	logic [31:0] rng_state = 32'he36b_707b;
	int          n_issued  = 0;
	string       cur_test  = "random";

	// Monitor state
	int     cycle      = 0;
	int     n_in       = 0;
	int     n_out      = 0;
	int     n_burst    = 0;
	logic   in_acc     = 1'b0;
	logic   stall_seen = 1'b0;
	word_t  held_sum;
	logic   held_cout;
	wide_t  exp_q[$];
	string  test_q[$];
	int     acc_q[$];
	wide_t  pop_total;
	string  pop_test;
	int     pop_cycle;

	always #20 clk = ~clk;

	ks_adder u_ks_adder (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.sum       (sum),
		.cout      (cout)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Reference model by plain wide addition
	function automatic wide_t model_add(input word_t x, input word_t y, input logic c);
		return wide_t'(x) + wide_t'(y) + wide_t'(c);
	endfunction

	task automatic report_mismatch(input string test_name, input wide_t expected,
			input wide_t actual);
		$display("mismatch %s: expected %0h actual %0h", test_name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic load_operands(input string test_name);
		int          idx;
		logic [31:0] r;
		idx = n_issued;
		n_issued++;
		cur_test = test_name;
		r = next_random();
		a   = word_t'(next_random());
		b   = word_t'(next_random());
		cin = r[0];
		case (idx)
			CORNER_RIPPLE: begin
				// Carry runs through every bit
				a        = '1;
				b        = '0;
				cin      = 1'b1;
				cur_test = "corner ripple";
			end
			CORNER_ONES: begin
				a        = '1;
				b        = '1;
				cin      = 1'b0;
				cur_test = "corner all ones";
			end
			CORNER_ONES_CIN: begin
				a        = '1;
				b        = '1;
				cin      = 1'b1;
				cur_test = "corner all ones cin";
			end
			CORNER_ZERO: begin
				a        = '0;
				b        = '0;
				cin      = 1'b1;
				cur_test = "corner zero cin";
			end
			default: begin
			end
		endcase
	endtask

	task automatic drive_random();
		logic [31:0] r;
		r = next_random();
		out_ready = (r % 32'd3) != 32'd0;
		// Hold a pending input until it is taken
		if (!(in_valid && !in_acc)) begin
			if (n_issued < NUM_ADDS && r[9:8] != 2'b00) begin
				load_operands("random");
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic run_burst();
		for (int i = 0; i < BURST_LEN; i++) begin
			out_ready = 1'b1;
			load_operands("burst");
			in_valid = 1'b1;
			@(negedge clk);
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		repeat (LATENCY + 3) @(negedge clk);
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		a         = '0;
		b         = '0;
		cin       = 1'b0;
		out_ready = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (!out_valid) else report_error("out_valid is high after reset");
		assert (in_ready) else report_error("in_ready is low after reset");

		while (n_out < NUM_ADDS) begin
			@(negedge clk);
			if (n_issued == BURST_AT && !(in_valid && !in_acc)) begin
				run_burst();
			end else begin
				drive_random();
			end
		end

		// Quiet tail to catch stray extra results
		in_valid  = 1'b0;
		out_ready = 1'b1;
		repeat (LATENCY + 3) @(negedge clk);

		assert (exp_q.size() == 0) else report_error("results still pending at end of run");
		assert (n_in == n_out && n_in == NUM_ADDS)
			else report_error("accepted input and output counts differ");
		assert (n_burst == BURST_LEN) else report_error("not every burst input was accepted");
		$display("ALL CHECKS PASSED");
		$finish;
	end

	//////////////////////////////
	// Monitor
	//////////////////////////////

	always @(posedge clk) begin
		if (rst_n) begin
			cycle++;
			assert (cycle <= TIMEOUT_CYCLES)
				else report_error($sformatf("run timed out after %0d cycles", cycle));

			// Stalled result must sit still
			if (stall_seen) begin
				assert (out_valid) else report_error("out_valid dropped while stalled");
				assert ({cout, sum} == {held_cout, held_sum})
					else report_mismatch("backpressure hold", {held_cout, held_sum},
						{cout, sum});
			end
			stall_seen = out_valid && !out_ready;
			held_sum   = sum;
			held_cout  = cout;

			if (in_valid && cur_test == "burst") begin
				assert (in_ready) else report_error("burst input was not accepted");
			end

			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0) else report_error("result with no pending input");
				pop_total = exp_q.pop_front();
				pop_test  = test_q.pop_front();
				pop_cycle = acc_q.pop_front();
				n_out++;
				assert ({cout, sum} == pop_total)
					else report_mismatch(pop_test, pop_total, {cout, sum});
				if (pop_test == "burst") begin
					assert (cycle - pop_cycle == LATENCY)
						else report_mismatch("burst latency", wide_t'(LATENCY),
							wide_t'(cycle - pop_cycle));
				end
			end

			in_acc = in_valid && in_ready;
			if (in_acc) begin
				exp_q.push_back(model_add(a, b, cin));
				test_q.push_back(cur_test);
				acc_q.push_back(cycle);
				n_in++;
				if (cur_test == "burst") begin
					n_burst++;
				end
			end
		end
	end

endmodule
